/* hw/display_pkg.sv */
/*
 * display package
 * types for screen coordinates shared by the timing and drawing logic
 */
package display_pkg;

    // coordinate width in bits
    // 10 bits covers the 800 pixel line and the 525 line frame
    localparam int CORDW = 10;

    // screen coordinate
    // used for both sx and sy and for the square origin
    typedef logic [CORDW-1:0] coord_t;

endpackage

/* hw/display_timings.sv */
/*
 * display timings for 640x480 at 60 Hz
 * counts screen coordinates and decodes sync, data enable and frame start
 */
`include "square_settings.svh"

module display_timings (
    input  logic                clk_pix,      // pixel clock
    input  logic                arst_n,       // active low async reset
    output display_pkg::coord_t sx,           // horizontal screen position
    output display_pkg::coord_t sy,           // vertical screen position
    output logic                hsync,        // active low
    output logic                vsync,        // active low
    output logic                de,           // high in the visible area
    output logic                frame_start   // one cycle on the final pixel
);
    import display_pkg::*;

    // wrap points of the two counters
    localparam coord_t H_LAST = coord_t'(`H_TOTAL - 1);  // 799
    localparam coord_t V_LAST = coord_t'(`V_TOTAL - 1);  // 524

    logic line_end;   // sx on last pixel of line
    logic frame_end;  // sy on last line of frame

    always_comb begin
        line_end  = (sx == H_LAST);
        frame_end = (sy == V_LAST);
    end

    // horizontal counter
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
        end else if (line_end) begin
            sx <= '0;  // back to start of line
        end else begin
            sx <= sx + coord_t'(1);
        end
    end

    // vertical counter only steps when sx wraps
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sy <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                sy <= '0;  // new frame
            end else begin
                sy <= sy + coord_t'(1);
            end
        end
    end

    // decode from current counter value
    always_comb begin
        // sync pulses sit after the front porch
        hsync = ~((sx > coord_t'(`H_FP_END)) && (sx <= coord_t'(`H_SYNC_END)));
        vsync = ~((sy > coord_t'(`V_FP_END)) && (sy <= coord_t'(`V_SYNC_END)));

        // visible area is top left corner of the counter space
        de = (sx < coord_t'(`H_ACTIVE)) && (sy < coord_t'(`V_ACTIVE));

        frame_start = line_end && frame_end;  // pixel (799,524)
    end

endmodule

/* hw/pixel_pkg.sv */
/*
 * pixel package
 * colour channel types for the 12-bit DVI Pmod
 */
package pixel_pkg;

    // bits per colour channel
    // the Pmod carries 4 bits each of red, green and blue
    localparam int CHANW = 4;

    // one colour channel
    typedef logic [CHANW-1:0] channel_t;

endpackage

/* hw/square_painter.sv */
/*
 * square painter
 * two stage pipeline that draws the square over the background
 * and registers sync, data enable and colour onto the DVI outputs
 */
`include "square_settings.svh"

module square_painter (
    input  logic                clk_pix,      // pixel clock
    input  logic                arst_n,       // active low async reset
    input  display_pkg::coord_t sx,           // current pixel column
    input  display_pkg::coord_t sy,           // current pixel row
    input  logic                hsync,        // sync for sx/sy
    input  logic                vsync,
    input  logic                de,
    input  logic                frame_start,  // last pixel of frame
    input  display_pkg::coord_t sq_x,         // requested square origin
    input  display_pkg::coord_t sq_y,
    output logic                dvi_hsync,    // DVI horizontal sync
    output logic                dvi_vsync,    // DVI vertical sync
    output logic                dvi_de,       // DVI data enable
    output pixel_pkg::channel_t dvi_r,        // DVI red
    output pixel_pkg::channel_t dvi_g,        // DVI green
    output pixel_pkg::channel_t dvi_b         // DVI blue
);
    import display_pkg::*;
    import pixel_pkg::*;

    // square origin held for a whole frame
    coord_t org_x;
    coord_t org_y;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            org_x <= '0;
            org_y <= '0;
        end else if (frame_start) begin
            org_x <= sq_x;  // takes effect from pixel (0,0)
            org_y <= sq_y;
        end
    end

    // hit test
    // offset from origin avoids overflow of org + SQ_SIZE
    coord_t dx;
    coord_t dy;
    logic   hit;

    always_comb begin
        dx  = sx - org_x;
        dy  = sy - org_y;
        hit = (sx >= org_x) && (dx < coord_t'(`SQ_SIZE))
            && (sy >= org_y) && (dy < coord_t'(`SQ_SIZE));
    end

    // stage 2 registers
    logic hit_q;
    logic hsync_q;
    logic vsync_q;
    logic de_q;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hit_q   <= 1'b0;
            hsync_q <= 1'b1;  // sync idles high
            vsync_q <= 1'b1;
            de_q    <= 1'b0;
        end else begin
            hit_q   <= hit;
            hsync_q <= hsync;
            vsync_q <= vsync;
            de_q    <= de;
        end
    end

    // colour select with blanking outside the visible area
    channel_t red;
    channel_t green;
    channel_t blue;

    always_comb begin
        if (!de_q) begin
            red   = '0;
            green = '0;
            blue  = '0;
        end else if (hit_q) begin
            red   = `SQ_R;  // orange
            green = `SQ_G;
            blue  = `SQ_B;
        end else begin
            red   = `BG_R;  // teal blue
            green = `BG_G;
            blue  = `BG_B;
        end
    end

    // stage 3 output registers
    // plays the role of the pin output flops
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            dvi_hsync <= 1'b1;
            dvi_vsync <= 1'b1;
            dvi_de    <= 1'b0;
            dvi_r     <= '0;
            dvi_g     <= '0;
            dvi_b     <= '0;
        end else begin
            dvi_hsync <= hsync_q;
            dvi_vsync <= vsync_q;
            dvi_de    <= de_q;
            dvi_r     <= red;
            dvi_g     <= green;
            dvi_b     <= blue;
        end
    end

endmodule

/* hw/top_square.sv */
/*
 * top square
 * 640x480 DVI test pattern with a movable 32x32 square
 */
module top_square (
    input  logic                clk_pix,    // pixel clock
    input  logic                arst_n,     // active low async reset
    input  display_pkg::coord_t sq_x,       // square origin column
    input  display_pkg::coord_t sq_y,       // square origin row
    output logic                dvi_hsync,  // DVI horizontal sync
    output logic                dvi_vsync,  // DVI vertical sync
    output logic                dvi_de,     // DVI data enable
    output pixel_pkg::channel_t dvi_r,      // 4-bit DVI red
    output pixel_pkg::channel_t dvi_g,      // 4-bit DVI green
    output pixel_pkg::channel_t dvi_b       // 4-bit DVI blue
);
    import display_pkg::*;

    // stage 1 to painter
    coord_t sx;
    coord_t sy;
    logic   hsync;
    logic   vsync;
    logic   de;
    logic   frame_start;

    display_timings i_display_timings (
        .clk_pix,
        .arst_n,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .frame_start
    );

    // stages 2 and 3 give 2 cycles of latency to the pins
    square_painter i_square_painter (
        .clk_pix,
        .arst_n,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .frame_start,
        .sq_x,
        .sq_y,
        .dvi_hsync,
        .dvi_vsync,
        .dvi_de,
        .dvi_r,
        .dvi_g,
        .dvi_b
    );

endmodule

/* include/square_settings.svh */
/*
 * settings for the top square design
 * 640x480 60 Hz display timings, square size and pattern colours
 */
`ifndef SQUARE_SETTINGS_SVH
`define SQUARE_SETTINGS_SVH

// horizontal timing in pixels
`define H_ACTIVE    640   // last visible pixel is 639
`define H_FP_END    655   // end of front porch
`define H_SYNC_END  751   // hsync low from 656 to here
`define H_TOTAL     800   // full line incl. blanking

// vertical timing in lines
`define V_ACTIVE    480   // last visible line is 479
`define V_FP_END    489   // end of front porch
`define V_SYNC_END  491   // vsync low on lines 490 and 491
`define V_TOTAL     525   // full frame incl. blanking

// square edge length
`define SQ_SIZE     32

// square colour (orange)
`define SQ_R        4'hF
`define SQ_G        4'h8
`define SQ_B        4'h0

// background colour (teal blue)
`define BG_R        4'h0
`define BG_G        4'h8
`define BG_B        4'hF

`endif

/* run_sim.sh */
#!/bin/sh
# build and run the top square testbench with Verilator
# exits 0 only when the simulation log holds the pass line

cd "$(dirname "$0")" || exit 1

TOP=top_square_tb
BUILD_DIR=build
LOG=sim.log
SIM="$BUILD_DIR/$TOP"

echo "building $TOP"
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module "$TOP" \
    -f top_square.f \
    --Mdir "$BUILD_DIR" \
    -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

if [ ! -x "$SIM" ]; then
    echo "simulation binary $SIM not found"
    exit 1
fi

echo "running $SIM"
"./$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    echo "result: passed"
    exit 0
fi

echo "result: failed, pass line not found in $LOG"
exit 1

/* top_square.f */
+incdir+include
hw/display_pkg.sv
hw/pixel_pkg.sv
hw/display_timings.sv
hw/square_painter.sv
hw/top_square.sv
verification/top_square_asserts.sv
verification/top_square_tb.sv

/* verification/top_square_asserts.sv */
/*
 * concurrent assertions on the DVI outputs of the top square design
 * sync versus data enable, blanking and hsync pulse width
 */
`include "square_settings.svh"

module top_square_asserts (
    input logic                clk_pix,
    input logic                arst_n,
    input logic                dvi_hsync,
    input logic                dvi_vsync,
    input logic                dvi_de,
    input pixel_pkg::channel_t dvi_r,
    input pixel_pkg::channel_t dvi_g,
    input pixel_pkg::channel_t dvi_b
);
    timeunit 1ns;
    timeprecision 100ps;

    import pixel_pkg::*;

    localparam int HSYNC_WIDTH = `H_SYNC_END - `H_FP_END;  // 96 pixels

    int low_count;  // cycles of the current hsync pulse

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            low_count <= 0;
        end else if (!dvi_hsync) begin
            low_count <= low_count + 1;
        end else begin
            low_count <= 0;  // idle high
        end
    end

    // no pixel data while a sync pulse is active
    de_outside_sync: assert property (@(posedge clk_pix) disable iff (!arst_n)
        dvi_de |-> (dvi_hsync && dvi_vsync))
        else $error("dvi_de high during a sync pulse");

    colour_blanked: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !dvi_de |-> (dvi_r == channel_t'(0) && dvi_g == channel_t'(0) && dvi_b == channel_t'(0)))
        else $error("colour not zero while dvi_de is low");

    // checked on the rising edge that ends each pulse
    hsync_width: assert property (@(posedge clk_pix) disable iff (!arst_n)
        $rose(dvi_hsync) |-> (low_count == HSYNC_WIDTH))
        else $error("hsync pulse lasted %0d cycles", low_count);

endmodule

bind top_square top_square_asserts i_top_square_asserts (
    .clk_pix   (clk_pix),
    .arst_n    (arst_n),
    .dvi_hsync (dvi_hsync),
    .dvi_vsync (dvi_vsync),
    .dvi_de    (dvi_de),
    .dvi_r     (dvi_r),
    .dvi_g     (dvi_g),
    .dvi_b     (dvi_b)
);

/* verification/top_square_tb.sv */
/*
 * testbench for the top square pattern generator
 * runs three frames and checks every DVI output pixel against a reference model
 */
`include "square_settings.svh"

module top_square_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import display_pkg::*;
    import pixel_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int LATENCY        = 2;                     // stage 2 and 3 registers
    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;   // 420000 pixels per frame
    localparam int NUM_FRAMES     = 3;
    localparam int RUN_CYCLES     = NUM_FRAMES * FRAME_CYCLES;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 40_000;   // reset and latency fit easily

    // expected value of all six outputs for one pixel
    typedef struct packed {
        logic     hsync;
        logic     vsync;
        logic     de;
        channel_t r;
        channel_t g;
        channel_t b;
    } pixel_exp_t;

    logic     clk_pix = 1'b0;
    logic     arst_n;
    coord_t   sq_x;
    coord_t   sq_y;
    logic     dvi_hsync;
    logic     dvi_vsync;
    logic     dvi_de;
    channel_t dvi_r;
    channel_t dvi_g;
    channel_t dvi_b;

    logic [15:0] lfsr_state  = 16'd4307;
    int          cycle_count = 0;   // every posedge, reset included
    int          pix_count   = 0;   // posedges since reset release
    logic        run_done    = 1'b0;
    coord_t      frame_org_x [0:NUM_FRAMES];   // square origin per frame
    coord_t      frame_org_y [0:NUM_FRAMES];

    top_square i_top_square (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .sq_x      (sq_x),
        .sq_y      (sq_y),
        .dvi_hsync (dvi_hsync),
        .dvi_vsync (dvi_vsync),
        .dvi_de    (dvi_de),
        .dvi_r     (dvi_r),
        .dvi_g     (dvi_g),
        .dvi_b     (dvi_b)
    );

    always #2 clk_pix = ~clk_pix;  // 4 ns period

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int count, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[14:0], lfsr_state[0]};
        end
    endtask

    // random origin that keeps the whole square visible
    task automatic new_square_pos(output coord_t x, output coord_t y);
        logic [15:0] raw;
        draw_bits(10, raw);
        x = coord_t'(int'(raw[9:0]) % (`H_ACTIVE - `SQ_SIZE));  // below 608
        draw_bits(9, raw);
        y = coord_t'(int'(raw[8:0]) % (`V_ACTIVE - `SQ_SIZE));  // below 448
    endtask

    // reset state of the output registers
    function automatic pixel_exp_t idle_pixel();
        pixel_exp_t p;
        p.hsync = 1'b1;
        p.vsync = 1'b1;
        p.de    = 1'b0;
        p.r     = 4'h0;
        p.g     = 4'h0;
        p.b     = 4'h0;
        return p;
    endfunction

    // expected outputs for one screen coordinate and the origin of its frame
    function automatic pixel_exp_t ref_pixel(input coord_t x, input coord_t y,
                                             input coord_t org_x, input coord_t org_y);
        pixel_exp_t p;
        int         xi;
        int         yi;
        int         ox;
        int         oy;
        logic       in_sq;
        xi = int'(x);
        yi = int'(y);
        ox = int'(org_x);
        oy = int'(org_y);
        p.hsync = !((xi >= `H_FP_END + 1) && (xi <= `H_SYNC_END));  // low 656..751
        p.vsync = !((yi >= `V_FP_END + 1) && (yi <= `V_SYNC_END));  // low 490..491
        p.de    = (xi < `H_ACTIVE) && (yi < `V_ACTIVE);
        in_sq   = (xi >= ox) && (xi < ox + `SQ_SIZE) && (yi >= oy) && (yi < oy + `SQ_SIZE);
        if (!p.de) begin
            p.r = 4'h0;  // blanking
            p.g = 4'h0;
            p.b = 4'h0;
        end else if (in_sq) begin
            p.r = `SQ_R;
            p.g = `SQ_G;
            p.b = `SQ_B;
        end else begin
            p.r = `BG_R;
            p.g = `BG_G;
            p.b = `BG_B;
        end
        return p;
    endfunction

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_sync(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h at pixel count %0d",
                     name, expected, actual, pix_count);
            abort_run();
        end
    endtask

    task automatic check_colour(input string name, input channel_t expected,
                                input channel_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h at pixel count %0d",
                     name, expected, actual, pix_count);
            abort_run();
        end
    endtask

    task automatic compare_pixel(input pixel_exp_t expected);
        check_sync("dvi_hsync", expected.hsync, dvi_hsync);
        check_sync("dvi_vsync", expected.vsync, dvi_vsync);
        check_sync("dvi_de", expected.de, dvi_de);
        check_colour("dvi_r", expected.r, dvi_r);
        check_colour("dvi_g", expected.g, dvi_g);
        check_colour("dvi_b", expected.b, dvi_b);
    endtask

    // comparing process, samples outputs on the falling edge
    initial begin : compare_outputs
        pixel_exp_t expected;
        int         idx;
        logic [1:0] frame_sel;
        coord_t     x;
        coord_t     y;
        frame_org_x[0] = '0;  // origin after reset
        frame_org_y[0] = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk_pix);
            compare_pixel(idle_pixel());
        end
        // reset was released on the last of those edges
        while (pix_count < RUN_CYCLES + LATENCY) begin
            @(negedge clk_pix);
            pix_count++;
            if (pix_count % FRAME_CYCLES == 0) begin
                frame_sel              = 2'(pix_count / FRAME_CYCLES);
                frame_org_x[frame_sel] = sq_x;  // taken on the last pixel of the frame
                frame_org_y[frame_sel] = sq_y;
            end
            if (pix_count < LATENCY) begin
                expected = idle_pixel();  // pipeline still holds reset values
            end else begin
                idx       = pix_count - LATENCY;
                frame_sel = 2'(idx / FRAME_CYCLES);
                x         = coord_t'(idx % `H_TOTAL);
                y         = coord_t'((idx / `H_TOTAL) % `V_TOTAL);
                expected  = ref_pixel(x, y, frame_org_x[frame_sel], frame_org_y[frame_sel]);
            end
            compare_pixel(expected);
        end
        run_done = 1'b1;
    end

    always @(posedge clk_pix) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // stimulus, driven on the falling edge
    initial begin
        arst_n = 1'b0;
        sq_x   = '0;  // frame 1 square in the top left corner
        sq_y   = '0;
        repeat (RESET_CYCLES) @(negedge clk_pix);
        arst_n = 1'b1;
        repeat (FRAME_CYCLES + FRAME_CYCLES / 2) @(negedge clk_pix);  // middle of frame 2
        new_square_pos(sq_x, sq_y);
        wait (run_done);
        $display("TEST PASS");
        $finish;
    end

endmodule
